/* blitter/blit_engine.sv */
`timescale 1ns/100ps

module blit_engine #(
    parameter int ADDR_W = 12
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  blit_pkg::blit_cfg_t  cfg_i,
    input  logic                 start_i,
    output blit_pkg::blit_stat_t stat_o,
    output logic                 rd_en_o,
    output logic [ADDR_W-1:0]    rd_addr_o,
    input  logic [15:0]          rd_data_i,
    output blit_pkg::vram_wr_t   wr_o
);
    import blit_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,        // one word issued per cycle
        DRAIN       // last write leaves the pipe
    } state_e;

    state_e state;

    // config captured at start, regs keep moving while busy
    blit_mode_e         mode_q;
    logic signed [15:0] rd_mod_q;
    logic signed [15:0] wr_mod_q;
    logic [3:0]         mask_q;
    logic [15:0]        width_q;
    logic [15:0]        fill_q;

    // address walk
    logic [15:0] rd_line;       // start of current source line
    logic [15:0] wr_line;       // start of current dest line
    logic [15:0] rd_addr;
    logic [15:0] wr_addr;
    logic [15:0] col;           // words left in line minus one
    logic [15:0] lines_left;
    logic [15:0] rd_next;
    logic [15:0] wr_next;
    logic        eol;
    logic        last;

    // write stage, travels alongside the read
    logic        s1_valid;
    logic [15:0] s1_wr_addr;
    logic        s1_last;

    assign eol     = (col == 16'd0);
    assign last    = eol && (lines_left == 16'd1);
    assign rd_next = rd_line + width_q + rd_mod_q;  // wraps mod 2^16
    assign wr_next = wr_line + width_q + wr_mod_q;

    // control state
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= IDLE;
            lines_left <= '0;
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
        end else begin
            s1_valid <= (state == RUN);
            s1_last  <= (state == RUN) && last;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state      <= RUN;
                        lines_left <= cfg_i.count;
                    end
                end
                RUN: begin
                    if (eol) begin
                        lines_left <= lines_left - 16'd1;
                        if (last) state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (s1_last) state <= IDLE;    // final word written this cycle
                end
                default: state <= IDLE;
            endcase
        end
    end

    // addresses and captured config
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            mode_q   <= cfg_i.mode;
            rd_mod_q <= cfg_i.rd_mod;
            wr_mod_q <= cfg_i.wr_mod;
            mask_q   <= cfg_i.wr_mask;
            width_q  <= cfg_i.width;
            fill_q   <= cfg_i.fill;
            rd_line  <= cfg_i.rd_addr;
            wr_line  <= cfg_i.wr_addr;
            rd_addr  <= cfg_i.rd_addr;
            wr_addr  <= cfg_i.wr_addr;
            col      <= cfg_i.width - 16'd1;
        end else if (state == RUN) begin
            s1_wr_addr <= wr_addr;
            if (eol) begin
                // next line start = line start + width + modulo
                rd_line <= rd_next;
                wr_line <= wr_next;
                rd_addr <= rd_next;
                wr_addr <= wr_next;
                col     <= width_q - 16'd1;
            end else begin
                rd_addr <= rd_addr + 16'd1;
                wr_addr <= wr_addr + 16'd1;
                col     <= col - 16'd1;
            end
        end
    end

    // fill mode skips the read
    assign rd_en_o   = (state == RUN) && (mode_q == BLIT_COPY);
    assign rd_addr_o = rd_addr[ADDR_W-1:0];

    always_comb begin
        wr_o.en       = s1_valid;
        wr_o.addr     = s1_wr_addr;
        wr_o.data     = (mode_q == BLIT_FILL) ? fill_q : rd_data_i;
        wr_o.nib_mask = mask_q;   // vram keeps masked-off nibbles
    end

    always_comb begin
        stat_o.busy        = (state != IDLE);
        stat_o.cur_rd_addr = rd_addr;
        stat_o.cur_wr_addr = wr_addr;
        stat_o.lines_left  = lines_left;
    end

    // pipeline must be empty once back in idle
    a_no_wr_idle: assert property (@(posedge clk) disable iff (reset_i)
        (state == IDLE) |-> !wr_o.en);

    // regs must hold off start until the engine is done
    a_start_idle: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> (state == IDLE));

endmodule

/* blitter/blit_regs.sv */
`timescale 1ns/100ps

module blit_regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 reg_wr_i,
    input  blit_pkg::blit_reg_e  reg_num_i,
    input  logic [15:0]          reg_data_i,
    output logic [15:0]          reg_rdata_o,
    input  blit_pkg::blit_stat_t stat_i,
    output blit_pkg::blit_cfg_t  cfg_o,
    output logic                 start_o
);
    import blit_pkg::*;

    blit_mode_e         mode_q;
    logic signed [15:0] rd_mod_q;
    logic signed [15:0] wr_mod_q;
    logic [3:0]         mask_q;
    logic [15:0]        width_q;
    logic [15:0]        rd_addr_q;
    logic [15:0]        wr_addr_q;
    logic [15:0]        fill_q;
    logic [15:0]        count_q;
    logic               wr_ok;      // host write accepted this cycle

    // start cycle counts as busy too, engine has not seen it yet
    assign wr_ok = reg_wr_i && !stat_i.busy && !start_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mode_q    <= BLIT_COPY;
            rd_mod_q  <= '0;
            wr_mod_q  <= '0;
            mask_q    <= '0;
            width_q   <= '0;
            rd_addr_q <= '0;
            wr_addr_q <= '0;
            fill_q    <= '0;
            count_q   <= '0;
            start_o   <= 1'b0;
        end else begin
            start_o <= wr_ok && (reg_num_i == COUNT) && (reg_data_i != 16'd0)
                       && (width_q != 16'd0);
            if (stat_i.busy) begin
                // follow the engine so final addresses remain after the blit
                rd_addr_q <= stat_i.cur_rd_addr;
                wr_addr_q <= stat_i.cur_wr_addr;
                count_q   <= stat_i.lines_left;
            end else if (wr_ok) begin
                case (reg_num_i)
                    MODE:    mode_q    <= blit_mode_e'(reg_data_i[0]);
                    RD_MOD:  rd_mod_q  <= reg_data_i;
                    WR_MOD:  wr_mod_q  <= reg_data_i;
                    WR_MASK: mask_q    <= reg_data_i[3:0];
                    WIDTH:   width_q   <= reg_data_i;
                    RD_ADDR: rd_addr_q <= reg_data_i;
                    WR_ADDR: wr_addr_q <= reg_data_i;
                    FILL:    fill_q    <= reg_data_i;
                    COUNT:   count_q   <= reg_data_i;
                    default: ;      // unused numbers, write dropped
                endcase
            end
        end
    end

    always_comb begin
        cfg_o.mode    = mode_q;
        cfg_o.rd_mod  = rd_mod_q;
        cfg_o.wr_mod  = wr_mod_q;
        cfg_o.wr_mask = mask_q;
        cfg_o.width   = width_q;
        cfg_o.rd_addr = rd_addr_q;
        cfg_o.wr_addr = wr_addr_q;
        cfg_o.fill    = fill_q;
        cfg_o.count   = count_q;
    end

    // read-back, one cycle after reg_num_i
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_rdata_o <= '0;
        end else begin
            case (reg_num_i)
                MODE:    reg_rdata_o <= {15'd0, mode_q};
                RD_MOD:  reg_rdata_o <= rd_mod_q;
                WR_MOD:  reg_rdata_o <= wr_mod_q;
                WR_MASK: reg_rdata_o <= {12'd0, mask_q};
                WIDTH:   reg_rdata_o <= width_q;
                RD_ADDR: reg_rdata_o <= stat_i.busy ? stat_i.cur_rd_addr : rd_addr_q;
                WR_ADDR: reg_rdata_o <= stat_i.busy ? stat_i.cur_wr_addr : wr_addr_q;
                FILL:    reg_rdata_o <= fill_q;
                COUNT:   reg_rdata_o <= stat_i.busy ? stat_i.lines_left : count_q;
                default: reg_rdata_o <= '0;
            endcase
        end
    end

    // engine must never be retriggered mid-blit
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i)
        !(start_o && stat_i.busy));

endmodule

/* build.f */
common/blit_pkg.sv
blitter/blit_regs.sv
blitter/blit_engine.sv
hdl/vram.sv
hdl/blit_top.sv
dv/blit_tb.sv

/* common/blit_pkg.sv */
package blit_pkg;

    // host register numbers
    typedef enum logic [3:0] {
        MODE    = 4'd0,     // bit 0 selects copy or fill
        RD_MOD  = 4'd1,     // signed read modulo, added per line
        WR_MOD  = 4'd2,     // signed write modulo
        WR_MASK = 4'd3,     // nibble write enables
        WIDTH   = 4'd4,     // words per line
        RD_ADDR = 4'd5,     // source start
        WR_ADDR = 4'd6,     // dest start
        FILL    = 4'd7,     // constant word for fill mode
        COUNT   = 4'd8      // line count, writing it starts a blit
    } blit_reg_e;

    typedef enum logic {
        BLIT_COPY = 1'b0,
        BLIT_FILL = 1'b1
    } blit_mode_e;

    // configuration as seen by the engine at start
    typedef struct packed {
        blit_mode_e         mode;
        logic signed [15:0] rd_mod;
        logic signed [15:0] wr_mod;
        logic [3:0]         wr_mask;
        logic [15:0]        width;
        logic [15:0]        rd_addr;
        logic [15:0]        wr_addr;
        logic [15:0]        fill;
        logic [15:0]        count;
    } blit_cfg_t;

    // live engine state for register read-back
    typedef struct packed {
        logic               busy;
        logic [15:0]        cur_rd_addr;
        logic [15:0]        cur_wr_addr;
        logic [15:0]        lines_left;
    } blit_stat_t;

    // one vram write, nibble enables in nib_mask
    typedef struct packed {
        logic               en;
        logic [15:0]        addr;       // only low ADDR_W bits reach the ram
        logic [15:0]        data;
        logic [3:0]         nib_mask;
    } vram_wr_t;

endpackage

/* dv/blit_tb.sv */
`timescale 1ns/100ps

module blit_tb;
    import blit_pkg::*;

    localparam int AW    = 12;
    localparam int WORDS = 2**AW;

    logic          clk;
    logic          reset_i;
    logic          reg_wr_i;
    blit_reg_e     reg_num_i;
    logic [15:0]   reg_data_i;
    logic [15:0]   reg_rdata_o;
    logic          host_mem_wr_i;
    logic [AW-1:0] host_mem_addr_i;
    logic [15:0]   host_mem_wdata_i;
    logic [15:0]   host_mem_rdata_o;
    logic          busy_o;

    logic [15:0] model [WORDS];     // expected vram contents
    logic [31:0] lfsr;
    string       test_name;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_err0;         // errors seen before the current test

    blit_top #(.ADDR_W(AW)) dut0 (
        .clk              (clk),
        .reset_i          (reset_i),
        .reg_wr_i         (reg_wr_i),
        .reg_num_i        (reg_num_i),
        .reg_data_i       (reg_data_i),
        .reg_rdata_o      (reg_rdata_o),
        .host_mem_wr_i    (host_mem_wr_i),
        .host_mem_addr_i  (host_mem_addr_i),
        .host_mem_wdata_i (host_mem_wdata_i),
        .host_mem_rdata_o (host_mem_rdata_o),
        .busy_o           (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // masked-off nibbles keep the old word
    function automatic logic [15:0] merge_nibbles(input logic [15:0] old_w,
            input logic [15:0] new_w, input logic [3:0] mask);
        logic [15:0] r;
        for (int n = 0; n < 4; n++) begin
            r[n*4 +: 4] = mask[n] ? new_w[n*4 +: 4] : old_w[n*4 +: 4];
        end
        return r;
    endfunction

    function automatic blit_cfg_t make_cfg(input blit_mode_e mode, input logic [15:0] rd,
            input logic [15:0] wr, input logic [15:0] w, input logic [15:0] c,
            input logic [15:0] rd_mod, input logic [15:0] wr_mod, input logic [3:0] mask,
            input logic [15:0] fill);
        blit_cfg_t cfg;
        cfg.mode    = mode;
        cfg.rd_addr = rd;
        cfg.wr_addr = wr;
        cfg.width   = w;
        cfg.count   = c;
        cfg.rd_mod  = rd_mod;
        cfg.wr_mod  = wr_mod;
        cfg.wr_mask = mask;
        cfg.fill    = fill;
        return cfg;
    endfunction

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic compare_word(input string what, input logic [15:0] exp,
            input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_cycles(input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("MISMATCH %s busy cycles expected %0d actual %0d", test_name, exp, act);
        end
    endtask

    // read-back shows up one cycle after the number
    task automatic read_reg(input blit_reg_e num, output logic [15:0] val);
        reg_num_i = num;
        @(negedge clk);
        val = reg_rdata_o;
    endtask

    task automatic compare_reg(input blit_reg_e num, input logic [15:0] exp);
        logic [15:0] val;
        read_reg(num, val);
        compare_word($sformatf("reg %0d", num), exp, val);
    endtask

    task automatic write_reg(input blit_reg_e num, input logic [15:0] val);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = val;
        @(negedge clk);
        reg_wr_i   = 1'b0;
    endtask

    task automatic write_mem(input logic [15:0] addr, input logic [15:0] data);
        host_mem_wr_i    = 1'b1;
        host_mem_addr_i  = addr[AW-1:0];
        host_mem_wdata_i = data;
        @(negedge clk);
        host_mem_wr_i    = 1'b0;
        model[addr[AW-1:0]] = data;
    endtask

    task automatic fill_random(input logic [15:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            write_mem(base + 16'(i), rand_bits(16));
        end
    endtask

    // whole memory against the model
    task automatic check_mem();
        for (int a = 0; a < WORDS; a++) begin
            host_mem_addr_i = AW'(a);
            @(negedge clk);
            compare_word($sformatf("vram[%h]", AW'(a)), model[a], host_mem_rdata_o);
        end
    endtask

    task automatic program_regs(input blit_cfg_t cfg);
        write_reg(MODE, {15'd0, cfg.mode});
        write_reg(RD_MOD, cfg.rd_mod);
        write_reg(WR_MOD, cfg.wr_mod);
        write_reg(WR_MASK, {12'd0, cfg.wr_mask});
        write_reg(WIDTH, cfg.width);
        write_reg(RD_ADDR, cfg.rd_addr);
        write_reg(WR_ADDR, cfg.wr_addr);
        write_reg(FILL, cfg.fill);
    endtask

    // walk the rectangle line by line, addresses wrap at 16 bits
    task automatic apply_model(input blit_cfg_t cfg, output logic [15:0] rd_end,
            output logic [15:0] wr_end);
        logic [15:0] rl;
        logic [15:0] wl;
        logic [15:0] s;
        logic [15:0] d;
        logic [15:0] data;
        rl = cfg.rd_addr;
        wl = cfg.wr_addr;
        for (int l = 0; l < int'(cfg.count); l++) begin
            for (int k = 0; k < int'(cfg.width); k++) begin
                s    = rl + 16'(k);
                d    = wl + 16'(k);
                data = (cfg.mode == BLIT_FILL) ? cfg.fill : model[s[AW-1:0]];
                model[d[AW-1:0]] = merge_nibbles(model[d[AW-1:0]], data, cfg.wr_mask);
            end
            rl = rl + cfg.width + cfg.rd_mod;     // next line start
            wl = wl + cfg.width + cfg.wr_mod;
        end
        rd_end = rl;
        wr_end = wl;
    endtask

    // count write, then busy within a few cycles
    task automatic start_blit(input logic [15:0] count);
        int n;
        write_reg(COUNT, count);
        n = 0;
        while (!busy_o && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!busy_o) begin
            $display("%s: blit did not start after the count write", test_name);
            errors++;
            finish_run();
        end
    endtask

    // exp_len of zero skips the busy length check
    task automatic wait_idle(input int exp_len);
        int n;
        n = 0;
        while (busy_o && n < 20000) begin
            n++;
            @(negedge clk);
        end
        if (busy_o) begin
            $display("%s: blit never finished", test_name);
            errors++;
            finish_run();
        end else if (exp_len > 0) begin
            compare_cycles(exp_len, n);
        end
    endtask

    task automatic run_blit(input blit_cfg_t cfg);
        logic [15:0] rd_end;
        logic [15:0] wr_end;
        program_regs(cfg);
        apply_model(cfg, rd_end, wr_end);
        start_blit(cfg.count);
        wait_idle(int'(cfg.width) * int'(cfg.count) + 1);
        compare_reg(RD_ADDR, rd_end);           // final addresses stay readable
        compare_reg(WR_ADDR, wr_end);
        compare_reg(COUNT, 16'd0);
        check_mem();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: bad, %0d errors", test_name, errors - test_err0);
        end
    endtask

    // pattern over the whole address
    task automatic init_mem();
        for (int a = 0; a < WORDS; a++) begin
            write_mem(16'(a), 16'(a * 40503) ^ 16'h3c5a);
        end
    endtask

    task automatic test_reg_readback();
        logic [15:0] vals [9] = '{16'h0001, 16'h1234, 16'hfedc, 16'h000b, 16'h0021,
                                  16'h0abc, 16'h0def, 16'h5aa5, 16'h0007};
        begin_test("reg_readback");
        for (int r = 0; r < 16; r++) begin
            compare_reg(blit_reg_e'(4'(r)), 16'd0);     // zero after reset
        end
        for (int r = 8; r >= 0; r--) begin
            write_reg(blit_reg_e'(4'(r)), vals[r]);     // count first, width still zero
        end
        for (int r = 9; r < 16; r++) begin
            write_reg(blit_reg_e'(4'(r)), 16'hffff);
        end
        for (int r = 0; r < 16; r++) begin
            compare_reg(blit_reg_e'(4'(r)), (r < 9) ? vals[r] : 16'd0);
        end
        end_test();
    endtask

    task automatic test_linear_copy();
        begin_test("linear_copy");
        fill_random(16'h100, 32);
        run_blit(make_cfg(BLIT_COPY, 16'h100, 16'h300, 16'd32, 16'd1, 16'd0, 16'd0,
                          4'hf, 16'd0));
        end_test();
    endtask

    task automatic test_rect_copy();
        begin_test("rect_copy");
        fill_random(16'h400, 32);
        run_blit(make_cfg(BLIT_COPY, 16'h400, 16'h500, 16'd5, 16'd4, 16'd3, 16'd7,
                          4'hf, 16'd0));
        fill_random(16'h600, 28);
        // negative write modulo, dest lines step downward
        run_blit(make_cfg(BLIT_COPY, 16'h600, 16'h7c0, 16'd5, 16'd4, 16'd2, 16'hfff1,
                          4'hf, 16'd0));
        end_test();
    endtask

    task automatic test_masked_fill();
        begin_test("masked_fill");
        fill_random(16'h800, 64);
        run_blit(make_cfg(BLIT_FILL, 16'h0, 16'h800, 16'd8, 16'd4, 16'd0, 16'd8,
                          4'hf, 16'ha5c3));
        run_blit(make_cfg(BLIT_FILL, 16'h0, 16'h800, 16'd8, 16'd4, 16'd0, 16'd8,
                          4'h5, 16'h1e2d));
        run_blit(make_cfg(BLIT_FILL, 16'h0, 16'h800, 16'd8, 16'd4, 16'd0, 16'd8,
                          4'h0, 16'hffff));      // nothing written
        end_test();
    endtask

    task automatic test_busy_rules();
        blit_cfg_t   cfg;
        logic [15:0] rd_end;
        logic [15:0] wr_end;
        logic [15:0] live;
        begin_test("busy_rules");
        cfg = make_cfg(BLIT_COPY, 16'h900, 16'hc00, 16'd0, 16'd3, 16'd0, 16'd0, 4'hf, 16'd0);
        program_regs(cfg);
        write_reg(COUNT, 16'd3);                    // zero width, no start
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (busy_o) begin
                errors++;
                $display("%s: busy rose although width is zero", test_name);
            end
        end
        check_mem();
        cfg = make_cfg(BLIT_COPY, 16'h900, 16'hc00, 16'd16, 16'd40, 16'd0, 16'd0, 4'hf, 16'd0);
        program_regs(cfg);
        apply_model(cfg, rd_end, wr_end);
        start_blit(16'd40);
        write_reg(WR_ADDR, 16'h0bee);               // dropped while busy
        write_reg(FILL, 16'hbeef);                  // plain register, must keep its value
        read_reg(COUNT, live);
        checks++;
        if (live == 16'd0 || live > 16'd40) begin
            errors++;
            $display("%s: live line count %0d is out of range", test_name, live);
        end
        for (int k = 1; k <= 3; k++) begin
            repeat (15) @(negedge clk);             // one line per 16 cycles
            compare_reg(COUNT, live - 16'(k));
        end
        wait_idle(0);
        compare_reg(RD_ADDR, rd_end);
        compare_reg(WR_ADDR, wr_end);
        compare_reg(COUNT, 16'd0);
        compare_reg(FILL, cfg.fill);
        check_mem();
        end_test();
    endtask

    task automatic test_random_blits();
        blit_mode_e  mode;
        logic [15:0] rd;
        logic [15:0] wr;
        logic [15:0] w;
        logic [15:0] c;
        logic [15:0] rd_mod;
        logic [15:0] wm;
        logic [15:0] mask;
        logic [15:0] fill;
        begin_test("random_blits");
        for (int i = 0; i < 10; i++) begin
            mode   = blit_mode_e'(rand_bits(1) != 16'd0);
            rd     = rand_bits(10);                 // source below 0x480
            wr     = 16'h900 + rand_bits(9);        // dest within 0x8c8..0xb87
            w      = 16'd1 + rand_bits(3);
            c      = 16'd1 + rand_bits(3);
            rd_mod = rand_bits(3);
            wm     = rand_bits(4);
            mask   = rand_bits(4);
            fill   = rand_bits(16);
            run_blit(make_cfg(mode, rd, wr, w, c, rd_mod, {{12{wm[3]}}, wm[3:0]},
                              mask[3:0], fill));
        end
        end_test();
    endtask

    initial begin
        reset_i          = 1'b1;
        reg_wr_i         = 1'b0;
        reg_num_i        = MODE;
        reg_data_i       = '0;
        host_mem_wr_i    = 1'b0;
        host_mem_addr_i  = '0;
        host_mem_wdata_i = '0;
        lfsr             = 32'he2213875;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        test_err0        = 0;
        test_name        = "init";
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        init_mem();
        test_reg_readback();
        test_linear_copy();
        test_rect_copy();
        test_masked_fill();
        test_busy_rules();
        test_random_blits();
        finish_run();
    end

endmodule

/* hdl/blit_top.sv */
`timescale 1ns/100ps

module blit_top #(
    parameter int ADDR_W = 12
) (
    input  logic                clk,
    input  logic                reset_i,
    // register port
    input  logic                reg_wr_i,
    input  blit_pkg::blit_reg_e reg_num_i,
    input  logic [15:0]         reg_data_i,
    output logic [15:0]         reg_rdata_o,
    // host memory port
    input  logic                host_mem_wr_i,
    input  logic [ADDR_W-1:0]   host_mem_addr_i,
    input  logic [15:0]         host_mem_wdata_i,
    output logic [15:0]         host_mem_rdata_o,
    output logic                busy_o
);
    import blit_pkg::*;

    blit_cfg_t         cfg;
    blit_stat_t        stat;
    logic              start;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [15:0]       rd_data;
    vram_wr_t          vram_wr;

    assign busy_o = stat.busy;

    blit_regs regs0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .reg_rdata_o (reg_rdata_o),
        .stat_i      (stat),
        .cfg_o       (cfg),
        .start_o     (start)
    );

    blit_engine #(.ADDR_W(ADDR_W)) engine0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .cfg_i     (cfg),
        .start_i   (start),
        .stat_o    (stat),
        .rd_en_o   (rd_en),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data),
        .wr_o      (vram_wr)
    );

    vram #(.ADDR_W(ADDR_W)) vram0 (
        .clk            (clk),
        .host_wr_i      (host_mem_wr_i),
        .host_addr_i    (host_mem_addr_i),
        .host_wdata_i   (host_mem_wdata_i),
        .host_rdata_o   (host_mem_rdata_o),
        .blit_rd_en_i   (rd_en),
        .blit_rd_addr_i (rd_addr),
        .blit_rd_data_o (rd_data),
        .blit_wr_i      (vram_wr)
    );

endmodule

/* hdl/vram.sv */
`timescale 1ns/100ps

module vram #(
    parameter int ADDR_W = 12
) (
    input  logic               clk,
    input  logic               host_wr_i,
    input  logic [ADDR_W-1:0]  host_addr_i,
    input  logic [15:0]        host_wdata_i,
    output logic [15:0]        host_rdata_o,
    input  logic               blit_rd_en_i,
    input  logic [ADDR_W-1:0]  blit_rd_addr_i,
    output logic [15:0]        blit_rd_data_o,
    input  blit_pkg::vram_wr_t blit_wr_i
);

    logic [15:0] mem [2**ADDR_W];   // no reset, contents loaded by host

    logic [ADDR_W-1:0] blit_wr_addr;

    assign blit_wr_addr = blit_wr_i.addr[ADDR_W-1:0];

    // host writes whole words, blitter per nibble
    always_ff @(posedge clk) begin
        if (host_wr_i) begin
            mem[host_addr_i] <= host_wdata_i;
        end else if (blit_wr_i.en) begin
            for (int n = 0; n < 4; n++) begin
                if (blit_wr_i.nib_mask[n]) begin
                    mem[blit_wr_addr][n*4 +: 4] <= blit_wr_i.data[n*4 +: 4];
                end
            end
        end
    end

    // registered reads, same-address write returns old word
    always_ff @(posedge clk) begin
        host_rdata_o <= mem[host_addr_i];
        if (blit_rd_en_i) blit_rd_data_o <= mem[blit_rd_addr_i];
    end

    // host may only write while the blitter is idle
    a_one_writer: assert property (@(posedge clk)
        !(host_wr_i && blit_wr_i.en));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the blitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module blit_tb -f build.f -o blit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/blit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
